// ==== sys_unit.f ====
design/sys_pkg.sv
design/sys_decode.sv
design/csr_file.sv
design/trap_redirect.sv
design/sys_unit.sv
dv/sys_unit_assert.sv
dv/sys_unit_checker.sv
dv/sys_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sys_unit_tb
FILELIST ?= sys_unit.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/sys_unit_tb.sv ====
`timescale 1ns/1ps

module sys_unit_tb;

	localparam sys_pkg::csr_data_t VENDOR_ID = 32'h0000_0A5C;
	localparam sys_pkg::csr_data_t ARCH_ID = 32'h8000_0017;
	localparam sys_pkg::csr_addr_t UNKNOWN_BASE = 12'h7C0;
	localparam int N_RMW = 60;
	localparam int N_TRAP = 4;
	localparam int N_BUSY = 20;
	localparam int N_BAD = 12;
	// four read sweeps of 11 commands and six writes in the identity test.
	localparam int N_CMDS = 4 * 11 + 6 + N_RMW + N_TRAP * 9 + N_BUSY + N_BAD;
	localparam int MAX_CYCLES = 20 * N_CMDS + 100;

	logic clock = 1'b0;
	logic reset;
	logic sys_valid;
	sys_pkg::inst_t inst;
	sys_pkg::csr_data_t pc;
	sys_pkg::csr_data_t src1;
	logic wb_ack;
	logic done;
	sys_pkg::csr_data_t result;
	sys_pkg::redirect_t redirect;
	logic busy;
	sys_pkg::csr_data_t mstatus;
	integer seed = 46316;
	int cycles = 0;
	int tests = 0;
	int last_errors = 0;
	sys_pkg::csr_addr_t addr_set [7] = '{sys_pkg::ADDR_MSTATUS, sys_pkg::ADDR_MTVEC,
		sys_pkg::ADDR_MSCRATCH, sys_pkg::ADDR_MEPC, sys_pkg::ADDR_MCAUSE,
		sys_pkg::ADDR_MVENDORID, sys_pkg::ADDR_MARCHID};

	always #20 clock = ~clock;

	sys_unit #(.MVENDORID(VENDOR_ID), .MARCHID(ARCH_ID)) i_dut (.*);

	sys_unit_checker #(.MVENDORID(VENDOR_ID), .MARCHID(ARCH_ID)) i_checker (.*);

	always @(posedge clock) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ####################################################################
	// stimulus helpers
	// ####################################################################

	function automatic sys_pkg::inst_t csr_inst(input sys_pkg::csr_addr_t a,
		input logic [2:0] f3, input logic [4:0] rs);
		return {a, rs, f3, 5'd1, 7'b1110011}; // rd is x1.
	endfunction

	function automatic sys_pkg::csr_addr_t pick_addr();
		logic [2:0] idx;
		idx = 3'($unsigned($random(seed)) % 7);
		if ($random(seed) % 4 == 0) return 12'($random(seed));
		return addr_set[idx];
	endfunction

	task automatic run_cmd(input sys_pkg::inst_t w, input sys_pkg::csr_data_t p,
		input sys_pkg::csr_data_t s);
		int delay;
		delay = $unsigned($random(seed)) % 4;
		sys_valid = 1'b1;
		inst = w;
		pc = p;
		src1 = s;
		@(posedge clock);
		#2;
		sys_valid = 1'b0;
		while (!done) begin
			@(posedge clock);
			#2;
		end
		repeat (delay) begin
			@(posedge clock);
			#2;
		end
		wb_ack = 1'b1;
		@(posedge clock);
		#2;
		wb_ack = 1'b0;
		while (busy) begin
			@(posedge clock);
			#2;
		end
	endtask

	task automatic read_back(input sys_pkg::csr_addr_t a);
		run_cmd(csr_inst(a, 3'b010, 5'd0), 32'd0, 32'd0); // csrrs with x0 only reads.
	endtask

	task automatic sweep_reads();
		foreach (addr_set[i]) begin
			read_back(addr_set[i]);
		end
		for (int i = 0; i < 4; i++) begin
			read_back(UNKNOWN_BASE + 12'(i));
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = i_checker.errors - last_errors;
		last_errors = i_checker.errors;
		tests++;
		$display("test %s finished with %0d errors", name, errs);
	endtask

	// ####################################################################
	// test sequence
	// ####################################################################

	initial begin
		logic [2:0] f3;
		sys_pkg::inst_t w;
		int total;
		reset = 1'b1;
		sys_valid = 1'b0;
		inst = '0;
		pc = '0;
		src1 = '0;
		wb_ack = 1'b0;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;

		sweep_reads();
		run_cmd(csr_inst(sys_pkg::ADDR_MVENDORID, 3'b001, 5'd0), 32'd0, $random(seed));
		run_cmd(csr_inst(sys_pkg::ADDR_MARCHID, 3'b101, 5'd31), 32'd0, 32'd0);
		for (int i = 0; i < 4; i++) begin
			run_cmd(csr_inst(UNKNOWN_BASE + 12'(i), 3'b001, 5'd0), 32'd0, $random(seed));
		end
		sweep_reads();
		end_test("reset_and_identity");

		for (int i = 0; i < N_RMW; i++) begin
			f3 = 3'($unsigned($random(seed)) % 3 + 1);
			if ($random(seed) % 2 == 0) f3[2] = 1'b1; // immediate form.
			run_cmd(csr_inst(pick_addr(), f3, 5'($random(seed))), $random(seed), $random(seed));
		end
		sweep_reads();
		end_test("read_modify_write");

		for (int i = 0; i < N_TRAP; i++) begin
			run_cmd(csr_inst(sys_pkg::ADDR_MTVEC, 3'b001, 5'd0), 32'd0, $random(seed));
			run_cmd(32'h0000_0073, $random(seed), 32'd0);
			read_back(sys_pkg::ADDR_MEPC);
			read_back(sys_pkg::ADDR_MCAUSE);
			read_back(sys_pkg::ADDR_MSTATUS);
		end
		end_test("ecall");

		for (int i = 0; i < N_TRAP; i++) begin
			run_cmd(csr_inst(sys_pkg::ADDR_MSTATUS, 3'b001, 5'd0), 32'd0, $random(seed));
			run_cmd(csr_inst(sys_pkg::ADDR_MEPC, 3'b001, 5'd0), 32'd0, $random(seed));
			run_cmd(32'h3020_0073, $random(seed), 32'd0);
			read_back(sys_pkg::ADDR_MSTATUS);
		end
		end_test("mret");

		for (int i = 0; i < N_BUSY; i++) begin
			case ($unsigned($random(seed)) % 3)
				0: run_cmd(32'h0000_0073, $random(seed), 32'd0);
				1: run_cmd(32'h3020_0073, $random(seed), 32'd0);
				default: run_cmd(csr_inst(pick_addr(), 3'b001, 5'd0), $random(seed), $random(seed));
			endcase
		end
		end_test("busy");

		for (int i = 0; i < N_BAD; i++) begin
			w = $random(seed);
			w[6:0] = 7'b1110011;
			w[14:12] = (i % 2 == 0) ? 3'b100 : 3'b000;
			if (i % 2 != 0) w[31:20] = 12'h123 + 12'(i); // neither ecall nor mret.
			run_cmd(w, $random(seed), $random(seed));
		end
		sweep_reads();
		end_test("malformed");

		total = i_checker.errors + i_dut.i_assert.failures;
		$display("tests %0d, checks %0d, errors %0d", tests, i_checker.checks, total);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== dv/sys_unit_checker.sv ====
`timescale 1ns/1ps

module sys_unit_checker #(
	parameter sys_pkg::csr_data_t MVENDORID = 32'h0,
	parameter sys_pkg::csr_data_t MARCHID = 32'h0
) (
	input logic clock,
	input logic reset,
	input logic sys_valid,
	input sys_pkg::inst_t inst,
	input sys_pkg::csr_data_t pc,
	input sys_pkg::csr_data_t src1,
	input logic wb_ack,
	input logic done,
	input sys_pkg::csr_data_t result,
	input sys_pkg::redirect_t redirect,
	input logic busy,
	input sys_pkg::csr_data_t mstatus
);

	sys_pkg::csr_data_t model [sys_pkg::csr_addr_t]; // only the writable csrs have entries.
	sys_pkg::csr_data_t result_exp;
	sys_pkg::csr_data_t target_exp;
	logic done_exp;
	logic busy_exp;
	logic redir_exp;
	int errors = 0;
	int checks = 0;

	function automatic sys_pkg::csr_data_t read_csr(input sys_pkg::csr_addr_t a);
		if (model.exists(a)) return model[a];
		if (a == sys_pkg::ADDR_MVENDORID) return MVENDORID;
		if (a == sys_pkg::ADDR_MARCHID) return MARCHID;
		return '0;
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// ####################################################################
	// reference model of one command
	// ####################################################################

	task automatic apply(input sys_pkg::inst_t w, input sys_pkg::csr_data_t p,
		input sys_pkg::csr_data_t s);
		logic [2:0] f3;
		sys_pkg::csr_addr_t a;
		sys_pkg::csr_data_t old;
		sys_pkg::csr_data_t opnd;
		f3 = w[14:12];
		a = w[31:20];
		old = read_csr(a);
		opnd = f3[2] ? {27'd0, w[19:15]} : s;
		result_exp = '0;
		redir_exp = 1'b0;
		if (w[6:0] == 7'b1110011) begin
			if (f3 == 3'b000 && a == 12'h000) begin // ecall.
				redir_exp = 1'b1;
				target_exp = model[sys_pkg::ADDR_MTVEC];
				model[sys_pkg::ADDR_MEPC] = p;
				model[sys_pkg::ADDR_MCAUSE] = sys_pkg::MCAUSE_ECALL;
				model[sys_pkg::ADDR_MSTATUS] = sys_pkg::MSTATUS_TRAP;
			end else if (f3 == 3'b000 && a == 12'h302) begin // mret.
				redir_exp = 1'b1;
				target_exp = model[sys_pkg::ADDR_MEPC];
				model[sys_pkg::ADDR_MSTATUS] = sys_pkg::MSTATUS_RET;
			end else if (f3[1:0] != 2'b00) begin
				result_exp = old;
				if (model.exists(a)) begin
					case (f3[1:0])
						2'b01: model[a] = opnd;
						2'b10: model[a] = old | opnd;
						default: model[a] = old & ~opnd;
					endcase
				end
			end
		end
	endtask

	// ####################################################################
	// comparison at every edge
	// ####################################################################

	always @(posedge clock) begin
		if (reset) begin
			model[sys_pkg::ADDR_MSTATUS] = '0;
			model[sys_pkg::ADDR_MTVEC] = '0;
			model[sys_pkg::ADDR_MSCRATCH] = '0;
			model[sys_pkg::ADDR_MEPC] = '0;
			model[sys_pkg::ADDR_MCAUSE] = '0;
			done_exp = 1'b0;
			busy_exp = 1'b0;
		end else begin
			compare("done", 32'(done_exp), 32'(done));
			compare("busy", 32'(busy_exp), 32'(busy));
			compare("mstatus", model[sys_pkg::ADDR_MSTATUS], mstatus);
			if (done_exp) begin
				compare("result", result_exp, result);
				compare("redirect.valid", 32'(redir_exp), 32'(redirect.valid));
				if (redir_exp) compare("redirect.target", target_exp, redirect.target);
			end else if (redirect.valid !== 1'b0) begin
				compare("redirect.valid", 32'd0, 32'(redirect.valid));
			end
			done_exp = sys_valid && !busy_exp; // a pulse while busy is dropped.
			if (done_exp) begin
				apply(inst, pc, src1);
				busy_exp = 1'b1;
			end else if (wb_ack) begin
				busy_exp = 1'b0;
			end
		end
	end

endmodule

// ==== dv/sys_unit_assert.sv ====
`timescale 1ns/1ps

module sys_unit_assert (
	input logic clock,
	input logic reset,
	input logic sys_valid,
	input logic busy,
	input logic done,
	input sys_pkg::redirect_t redirect
);

	int failures = 0; // read by the testbench at the end of the run.

	no_valid_while_busy: assert property (@(posedge clock) disable iff (reset)
		busy |-> !sys_valid)
		else begin
			failures++;
			$error("sys_valid pulsed while busy is high");
		end

	done_after_valid: assert property (@(posedge clock) disable iff (reset)
		(sys_valid && !busy) |=> done)
		else begin
			failures++;
			$error("done did not follow an accepted sys_valid by one cycle");
		end

	redirect_with_done: assert property (@(posedge clock) disable iff (reset)
		redirect.valid |-> done)
		else begin
			failures++;
			$error("redirect.valid raised without done");
		end

endmodule

bind sys_unit sys_unit_assert i_assert (.*);

// ==== design/sys_unit.sv ====
`timescale 1ns/1ps

module sys_unit #(
	parameter sys_pkg::csr_data_t MVENDORID = 32'h7973_7978,
	parameter sys_pkg::csr_data_t MARCHID = 32'h015F_DE6D
) (
	input logic clock,
	input logic reset,
	input logic sys_valid,
	input sys_pkg::inst_t inst,
	input sys_pkg::csr_data_t pc,
	input sys_pkg::csr_data_t src1,
	input logic wb_ack,
	output logic done,
	output sys_pkg::csr_data_t result,
	output sys_pkg::redirect_t redirect,
	output logic busy,
	output sys_pkg::csr_data_t mstatus
);

	sys_pkg::sys_cmd_t cmd;
	sys_pkg::csr_data_t rd_data;
	sys_pkg::redirect_t trap;
	logic csr_commit;

	// the csr file must not commit a command that the redirect side drops.
	assign csr_commit = sys_valid && !busy;

	sys_decode i_decode (
		.inst(inst),
		.pc(pc),
		.src1(src1),
		.cmd(cmd)
	);

	csr_file #(
		.MVENDORID(MVENDORID),
		.MARCHID(MARCHID)
	) i_csr_file (
		.clock(clock),
		.reset(reset),
		.sys_valid(csr_commit),
		.cmd(cmd),
		.rd_data(rd_data),
		.trap(trap),
		.mstatus(mstatus)
	);

	trap_redirect i_trap_redirect (
		.clock(clock),
		.reset(reset),
		.sys_valid(sys_valid),
		.wb_ack(wb_ack),
		.rd_data(rd_data),
		.trap(trap),
		.done(done),
		.result(result),
		.redirect(redirect),
		.busy(busy)
	);

endmodule

// ==== design/trap_redirect.sv ====
`timescale 1ns/1ps

module trap_redirect (
	input logic clock,
	input logic reset,
	input logic sys_valid,
	input logic wb_ack,
	input sys_pkg::csr_data_t rd_data,
	input sys_pkg::redirect_t trap,
	output logic done,
	output sys_pkg::csr_data_t result,
	output sys_pkg::redirect_t redirect,
	output logic busy
);

	sys_pkg::sys_state_e state_q;
	sys_pkg::sys_state_e state_d;
	logic accept;

	// a pulse that arrives while busy is dropped.
	assign accept = sys_valid && (state_q == sys_pkg::ST_IDLE);

	// ####################################################################
	// state machine
	// ####################################################################

	always_comb begin
		state_d = state_q;
		case (state_q)
			sys_pkg::ST_IDLE: if (accept) state_d = sys_pkg::ST_BUSY;
			sys_pkg::ST_BUSY: if (wb_ack) state_d = sys_pkg::ST_IDLE;
			default: state_d = sys_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= sys_pkg::ST_IDLE;
			done <= 1'b0;
			redirect.valid <= 1'b0;
		end else begin
			state_q <= state_d;
			done <= accept; // one cycle after sys_valid.
			redirect.valid <= accept && trap.valid;
		end
	end

	assign busy = (state_q == sys_pkg::ST_BUSY);

	// ####################################################################
	// payload
	// ####################################################################

	// result holds until the next accepted command.
	always_ff @(posedge clock) begin
		if (accept) begin
			result <= rd_data;
			redirect.target <= trap.target;
		end
	end

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/1ps

module csr_file #(
	parameter sys_pkg::csr_data_t MVENDORID = 32'h7973_7978,
	parameter sys_pkg::csr_data_t MARCHID = 32'h015F_DE6D
) (
	input logic clock,
	input logic reset,
	input logic sys_valid,
	input sys_pkg::sys_cmd_t cmd,
	output sys_pkg::csr_data_t rd_data,
	output sys_pkg::redirect_t trap,
	output sys_pkg::csr_data_t mstatus
);

	sys_pkg::csr_data_t mstatus_q;
	sys_pkg::csr_data_t mtvec_q;
	sys_pkg::csr_data_t mepc_q;
	sys_pkg::csr_data_t mcause_q;
	sys_pkg::csr_data_t mscratch_q;

	sys_pkg::csr_data_t old_value;
	sys_pkg::csr_data_t new_value;
	logic is_access;
	logic is_ecall;
	logic is_mret;

	assign is_ecall = (cmd.kind == sys_pkg::KIND_ECALL);
	assign is_mret = (cmd.kind == sys_pkg::KIND_MRET);
	assign is_access = (cmd.kind == sys_pkg::KIND_WRITE) ||
		(cmd.kind == sys_pkg::KIND_SET) ||
		(cmd.kind == sys_pkg::KIND_CLEAR);

	// ####################################################################
	// read
	// ####################################################################

	always_comb begin
		case (cmd.addr)
			sys_pkg::ADDR_MSTATUS: old_value = mstatus_q;
			sys_pkg::ADDR_MTVEC: old_value = mtvec_q;
			sys_pkg::ADDR_MSCRATCH: old_value = mscratch_q;
			sys_pkg::ADDR_MEPC: old_value = mepc_q;
			sys_pkg::ADDR_MCAUSE: old_value = mcause_q;
			sys_pkg::ADDR_MVENDORID: old_value = MVENDORID;
			sys_pkg::ADDR_MARCHID: old_value = MARCHID;
			default: old_value = '0;
		endcase
	end

	assign rd_data = old_value; // rd always gets the value before the write.

	// ####################################################################
	// read-modify-write
	// ####################################################################

	always_comb begin
		case (cmd.kind)
			sys_pkg::KIND_WRITE: new_value = cmd.wdata;
			sys_pkg::KIND_SET: new_value = old_value | cmd.wdata;
			sys_pkg::KIND_CLEAR: new_value = old_value & ~cmd.wdata;
			default: new_value = old_value;
		endcase
	end

	// ####################################################################
	// trap and return targets
	// ####################################################################

	always_comb begin
		trap.valid = is_ecall || is_mret;
		if (is_ecall) begin
			trap.target = mtvec_q;
		end else if (is_mret) begin
			trap.target = mepc_q;
		end else begin
			trap.target = '0;
		end
	end

	// ####################################################################
	// registers
	// ####################################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus_q <= '0;
			mtvec_q <= '0;
			mepc_q <= '0;
			mcause_q <= '0;
			mscratch_q <= '0;
		end else if (sys_valid) begin
			if (is_ecall) begin
				mstatus_q <= sys_pkg::MSTATUS_TRAP;
				mepc_q <= cmd.pc; // pc of the ecall itself.
				mcause_q <= sys_pkg::MCAUSE_ECALL;
			end else if (is_mret) begin
				mstatus_q <= sys_pkg::MSTATUS_RET;
			end else if (is_access) begin
				// identity and unknown addresses fall through unwritten.
				case (cmd.addr)
					sys_pkg::ADDR_MSTATUS: begin
						mstatus_q <= new_value;
					end
					sys_pkg::ADDR_MTVEC: begin
						mtvec_q <= new_value;
					end
					sys_pkg::ADDR_MSCRATCH: begin
						mscratch_q <= new_value;
					end
					sys_pkg::ADDR_MEPC: begin
						mepc_q <= new_value;
					end
					sys_pkg::ADDR_MCAUSE: begin
						mcause_q <= new_value;
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign mstatus = mstatus_q;

endmodule

// ==== design/sys_decode.sv ====
`timescale 1ns/1ps

module sys_decode (
	input sys_pkg::inst_t inst,
	input sys_pkg::csr_data_t pc,
	input sys_pkg::csr_data_t src1,
	output sys_pkg::sys_cmd_t cmd
);

	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
	localparam sys_pkg::csr_addr_t IMM_ECALL = 12'h000;
	localparam sys_pkg::csr_addr_t IMM_MRET = 12'h302;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] zimm;
	sys_pkg::csr_addr_t imm;
	logic is_system;

	// ####################################################################
	// instruction fields
	// ####################################################################

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign zimm = inst[19:15]; // the rs1 field doubles as the immediate.
	assign imm = inst[31:20];
	assign is_system = (opcode == OPCODE_SYSTEM);

	// ####################################################################
	// command
	// ####################################################################

	always_comb begin
		cmd.kind = sys_pkg::KIND_NONE;
		cmd.addr = '0; // address zero is not implemented and reads as zero.
		cmd.wdata = '0;
		cmd.pc = pc;

		if (is_system) begin
			case (funct3)
				3'b000: begin
					if (imm == IMM_ECALL) begin
						cmd.kind = sys_pkg::KIND_ECALL;
					end else if (imm == IMM_MRET) begin
						cmd.kind = sys_pkg::KIND_MRET;
					end
				end
				3'b100: begin
					cmd.kind = sys_pkg::KIND_NONE; // reserved encoding.
				end
				default: begin
					cmd.addr = imm;
					if (funct3[2]) begin
						cmd.wdata = {27'd0, zimm};
					end else begin
						cmd.wdata = src1;
					end

					// register and immediate forms share the low two bits.
					case (funct3[1:0])
						2'b01: cmd.kind = sys_pkg::KIND_WRITE;
						2'b10: cmd.kind = sys_pkg::KIND_SET;
						default: cmd.kind = sys_pkg::KIND_CLEAR;
					endcase
				end
			endcase
		end
	end

endmodule

// ==== design/sys_pkg.sv ====
package sys_pkg;

	// ####################################################################
	// widths
	// ####################################################################

	typedef logic [31:0] csr_data_t; // register values, operands, pc and targets.
	typedef logic [11:0] csr_addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [2:0] sys_kind_t;

	// ####################################################################
	// command kinds
	// ####################################################################

	localparam sys_kind_t KIND_NONE = 3'd0;
	localparam sys_kind_t KIND_WRITE = 3'd1;
	localparam sys_kind_t KIND_SET = 3'd2;
	localparam sys_kind_t KIND_CLEAR = 3'd3;
	localparam sys_kind_t KIND_ECALL = 3'd4;
	localparam sys_kind_t KIND_MRET = 3'd5;

	// ####################################################################
	// csr addresses and trap values
	// ####################################################################

	localparam csr_addr_t ADDR_MSTATUS = 12'h300;
	localparam csr_addr_t ADDR_MTVEC = 12'h305;
	localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
	localparam csr_addr_t ADDR_MEPC = 12'h341;
	localparam csr_addr_t ADDR_MCAUSE = 12'h342;
	localparam csr_addr_t ADDR_MVENDORID = 12'hF11; // read only.
	localparam csr_addr_t ADDR_MARCHID = 12'hF12; // read only.

	// mpp set to machine mode on trap entry.
	localparam csr_data_t MSTATUS_TRAP = 32'h0000_1800;
	localparam csr_data_t MSTATUS_RET = 32'h0000_0000;
	localparam csr_data_t MCAUSE_ECALL = 32'd11; // environment call from m-mode.

	// ####################################################################
	// structs and states
	// ####################################################################

	// one decoded system command, 79 bits.
	typedef struct packed {
		sys_kind_t kind;
		csr_addr_t addr;
		csr_data_t wdata; // rs1 or the zero-extended immediate.
		csr_data_t pc;
	} sys_cmd_t;

	// fetch redirect, 33 bits.
	typedef struct packed {
		logic valid;
		csr_data_t target;
	} redirect_t;

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} sys_state_e;

endpackage
